// File: design/vstu_defines.svh
//////////////////////////////////////////////////////////////////////
// Vector store unit sizing macros
// Lane count, data widths, queue depth and length limits
//////////////////////////////////////////////////////////////////////
`ifndef VSTU_DEFINES_SVH
`define VSTU_DEFINES_SVH

// Lane side
`define VSTU_NR_LANES 4
`define VSTU_LANE_W 64

// Memory side, one W beat
`define VSTU_AXI_DATA_W 64
`define VSTU_LEN_W 8

// Instruction tracking
`define VSTU_QUEUE_DEPTH 4
`define VSTU_ID_W 3
`define VSTU_MAX_VL 128

`endif

// File: design/vstu_pkg.sv
//////////////////////////////////////////////////////////////////////
// Vector store unit types
// Element width encoding, store instruction and burst size helpers
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "vstu_defines.svh"

package vstu_pkg;

  // Element width, value is log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Byte count of one instruction's stream, up to VL times 8
  typedef logic [$clog2(`VSTU_MAX_VL*8):0] nbytes_t;

  typedef struct packed {
    logic [`VSTU_ID_W-1:0] id;
    logic [31:0]           addr;
    logic [7:0]            vl;
    eew_e                  eew;
    logic                  vm;    // 1 means unmasked
  } store_req_t;

  // Element bytes in element order
  function automatic nbytes_t stream_bytes(store_req_t r);
    return nbytes_t'(r.vl) << r.eew;
  endfunction

  // W beats of the burst, start offset included
  function automatic logic [`VSTU_LEN_W:0] beat_count(store_req_t r);
    nbytes_t span;
    span = nbytes_t'(r.addr[2:0]) + stream_bytes(r) + nbytes_t'(7);
    return span[$bits(nbytes_t)-1:3];
  endfunction

endpackage

`default_nettype wire

// File: design/vstu_if.sv
//////////////////////////////////////////////////////////////////////
// Vector store unit internal interfaces
// Issued instruction broadcast and the sequential chunk stream
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "vstu_defines.svh"

// Oldest unfinished instruction, shared by the datapath blocks
interface issue_if import vstu_pkg::*;;
  logic       valid;
  store_req_t req;
  logic       issue_done;  // Last W beat handed over

  modport queue (output valid, output req, input issue_done);
  modport gen   (input valid, input req, input issue_done);
  modport pack  (input valid, input req, output issue_done);
endinterface

// 8-byte chunks in stream order, valid/ready
interface chunk_if;
  logic [`VSTU_AXI_DATA_W-1:0]   data;
  logic [`VSTU_AXI_DATA_W/8-1:0] strb;
  logic [3:0]                    nbytes;  // Leading valid bytes, 1 to 8
  logic                          valid;
  logic                          ready;

  modport src (output data, output strb, output nbytes, output valid, input ready);
  modport snk (input data, input strb, input nbytes, input valid, output ready);
endinterface

`default_nettype wire

// File: design/vstu_insn_queue.sv
//////////////////////////////////////////////////////////////////////
// Vector store instruction queue
// Holds stores through the accept, issue and commit phases and
// retires one per B response
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "vstu_defines.svh"

module vstu_insn_queue import vstu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  store_req_t            req_i,
  input  logic                  b_valid_i,
  output logic                  b_ready_o,
  output logic                  done_valid_o,
  output logic [`VSTU_ID_W-1:0] done_id_o,
  output logic                  store_pending_o,
  issue_if.queue                issue
);

  store_req_t mem_q [`VSTU_QUEUE_DEPTH];

  // Pointers wrap naturally, depth is a power of two
  logic [$clog2(`VSTU_QUEUE_DEPTH)-1:0] accept_ptr_q, issue_ptr_q, commit_ptr_q;
  // Instructions not yet issued / not yet committed
  logic [$clog2(`VSTU_QUEUE_DEPTH):0]   issue_cnt_q, commit_cnt_q, commit_cnt_d;
  logic                                 accept, b_fire;

  assign accept = req_valid_i && req_ready_o;
  assign b_fire = b_valid_i && b_ready_o;

  // Issued but still waiting on B
  assign b_ready_o       = commit_cnt_q != issue_cnt_q;
  assign store_pending_o = commit_cnt_q != '0;

  assign issue.valid = issue_cnt_q != '0;
  assign issue.req   = mem_q[issue_ptr_q];

  assign commit_cnt_d = commit_cnt_q + accept - b_fire;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_ptr_q <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      req_ready_o  <= 1'b0;
      done_valid_o <= 1'b0;
    end else begin
      if (accept) accept_ptr_q <= accept_ptr_q + 1'b1;
      if (issue.issue_done) issue_ptr_q <= issue_ptr_q + 1'b1;
      if (b_fire) commit_ptr_q <= commit_ptr_q + 1'b1;
      issue_cnt_q  <= issue_cnt_q + accept - issue.issue_done;
      commit_cnt_q <= commit_cnt_d;
      // Registered full flag, low while four are held
      req_ready_o  <= commit_cnt_d != `VSTU_QUEUE_DEPTH;
      done_valid_o <= b_fire;
    end
  end

  // Instruction storage and done id
  always_ff @(posedge clk_i) begin
    if (accept) mem_q[accept_ptr_q] <= req_i;
    if (b_fire) done_id_o <= mem_q[commit_ptr_q].id;
  end

endmodule

`default_nettype wire

// File: design/vstu_addrgen.sv
//////////////////////////////////////////////////////////////////////
// Vector store address generator
// One AW burst per issued store, aligned address and beat count
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "vstu_defines.svh"

module vstu_addrgen import vstu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  issue_if.gen                   issue,
  output logic [31:0]            aw_addr_o,
  output logic [`VSTU_LEN_W-1:0] aw_len_o,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i
);

  // Burst of the current instruction already raised
  logic                 sent_q;
  logic                 raise;
  logic [`VSTU_LEN_W:0] beats;

  assign beats = beat_count(issue.req);
  // Previous burst must have left the AW port
  assign raise = issue.valid && !sent_q && !aw_valid_o && !issue.issue_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_valid_o <= 1'b0;
      sent_q     <= 1'b0;
    end else begin
      if (raise) begin
        aw_valid_o <= 1'b1;
      end else if (aw_ready_i) begin
        aw_valid_o <= 1'b0;
      end
      // W may finish first, so the flag tracks the issue slot
      if (issue.issue_done) begin
        sent_q <= 1'b0;
      end else if (raise) begin
        sent_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (raise) begin
      aw_addr_o <= {issue.req.addr[31:3], 3'b000};
      aw_len_o  <= beats[`VSTU_LEN_W-1:0] - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/vstu_operand_collector.sv
//////////////////////////////////////////////////////////////////////
// Vector store operand collector
// Undoes the lane element shuffle and streams 8-byte chunks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "vstu_defines.svh"

module vstu_operand_collector import vstu_pkg::*; (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  issue_if.gen                                         issue,
  input  logic [`VSTU_NR_LANES-1:0][`VSTU_LANE_W-1:0]   lane_data_i,
  input  logic [`VSTU_NR_LANES-1:0][`VSTU_LANE_W/8-1:0] lane_mask_i,
  input  logic                                         lane_valid_i,
  output logic                                         lane_ready_o,
  chunk_if.src                                         chunk
);

  logic         active_q, full_q;
  nbytes_t      rem_q;         // Stream bytes still to come from lanes
  logic [5:0]   word_bytes;    // Stream bytes in the next lane transfer
  logic [5:0]   word_bytes_q;
  logic [5:0]   left;          // Bytes left in the latched word
  logic [1:0]   cidx_q;
  logic [255:0] shuf_data, buf_data_q;
  logic [31:0]  shuf_strb, buf_strb_q;
  logic         lane_fire, chunk_fire;

  assign word_bytes = (rem_q > nbytes_t'(32)) ? 6'd32 : rem_q[5:0];
  assign lane_ready_o = active_q && !full_q && (rem_q != '0);
  assign lane_fire    = lane_valid_i && lane_ready_o;

  // Byte s of the word is element s >> eew, which sits in lane e % 4
  always_comb begin
    int unsigned e, lane, pos;
    shuf_data = '0;
    shuf_strb = '0;
    for (int unsigned s = 0; s < 32; s++) begin
      e    = s >> issue.req.eew;
      lane = e % `VSTU_NR_LANES;
      pos  = ((e / `VSTU_NR_LANES) << issue.req.eew) + (s - (e << issue.req.eew));
      // Bytes past the stream end stay zero for the packer
      if (s < word_bytes) begin
        shuf_data[s*8 +: 8] = lane_data_i[lane][pos*8 +: 8];
        // Mask bit taken at the element's first byte
        shuf_strb[s] = issue.req.vm ||
                       lane_mask_i[lane][(e / `VSTU_NR_LANES) << issue.req.eew];
      end
    end
  end

  assign left         = word_bytes_q - {1'b0, cidx_q, 3'b000};
  assign chunk.valid  = full_q;
  assign chunk.data   = buf_data_q[cidx_q*64 +: 64];
  assign chunk.strb   = buf_strb_q[cidx_q*8 +: 8];
  assign chunk.nbytes = (left > 6'd8) ? 4'd8 : left[3:0];
  assign chunk_fire   = chunk.valid && chunk.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      full_q   <= 1'b0;
      rem_q    <= '0;
      cidx_q   <= '0;
    end else begin
      // Load the byte count once per instruction
      if (issue.issue_done) begin
        active_q <= 1'b0;
      end else if (issue.valid && !active_q) begin
        active_q <= 1'b1;
        rem_q    <= stream_bytes(issue.req);
      end
      if (lane_fire) begin
        full_q <= 1'b1;
        cidx_q <= '0;
        rem_q  <= rem_q - nbytes_t'(word_bytes);
      end else if (chunk_fire) begin
        // Trailing empty chunks of a short word are skipped
        if (left <= 6'd8) full_q <= 1'b0;
        cidx_q <= cidx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_fire) begin
      buf_data_q   <= shuf_data;
      buf_strb_q   <= shuf_strb;
      word_bytes_q <= word_bytes;
    end
  end

endmodule

`default_nettype wire

// File: design/vstu_beat_packer.sv
//////////////////////////////////////////////////////////////////////
// Vector store beat packer
// Realigns the chunk stream to the burst offset and drives W beats
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "vstu_defines.svh"

module vstu_beat_packer import vstu_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  issue_if.pack                         issue,
  chunk_if.snk                          chunk,
  output logic [`VSTU_AXI_DATA_W-1:0]   w_data_o,
  output logic [`VSTU_AXI_DATA_W/8-1:0] w_strb_o,
  output logic                          w_last_o,
  output logic                          w_valid_o,
  input  logic                          w_ready_i
);

  logic                 active_q, flush_q;
  logic [2:0]           fill_q;            // Next free byte of the open beat
  nbytes_t              rem_q;             // Stream bytes not yet received
  logic [`VSTU_LEN_W:0] beat_cnt_q, beats;
  logic [63:0]          acc_data_q;        // Residue carried into the open beat
  logic [7:0]           acc_strb_q;
  logic [127:0]         wide_data;
  logic [15:0]          wide_strb;
  logic [3:0]           new_fill;
  logic                 out_free, take, last_chunk, emit, load;

  assign beats    = beat_count(issue.req);
  assign load     = issue.valid && !active_q;
  assign out_free = !w_valid_o || w_ready_i;

  assign chunk.ready = active_q && !flush_q && out_free;
  assign take        = chunk.valid && chunk.ready;
  assign last_chunk  = rem_q == nbytes_t'(chunk.nbytes);

  // Chunk bytes above nbytes arrive as zero
  assign wide_data = {64'b0, acc_data_q} | ({64'b0, chunk.data} << {fill_q, 3'b000});
  assign wide_strb = {8'b0, acc_strb_q} | ({8'b0, chunk.strb} << fill_q);
  assign new_fill  = fill_q + chunk.nbytes;

  // Full beat, stream end, or the tail beat left over after the end
  assign emit = (flush_q && out_free) || (take && (new_fill[3] || last_chunk));

  assign issue.issue_done = w_valid_o && w_ready_i && w_last_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q   <= 1'b0;
      flush_q    <= 1'b0;
      w_valid_o  <= 1'b0;
      fill_q     <= '0;
      rem_q      <= '0;
      beat_cnt_q <= '0;
    end else begin
      if (emit) begin
        w_valid_o  <= 1'b1;
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end else if (w_ready_i) begin
        w_valid_o <= 1'b0;
      end
      if (issue.issue_done) begin
        active_q <= 1'b0;
      end else if (load) begin
        active_q   <= 1'b1;
        fill_q     <= issue.req.addr[2:0];
        rem_q      <= stream_bytes(issue.req);
        beat_cnt_q <= '0;
      end
      if (flush_q && out_free) begin
        flush_q <= 1'b0;
      end else if (take) begin
        flush_q <= last_chunk && (new_fill > 4'd8);
        fill_q  <= new_fill[2:0];
        rem_q   <= rem_q - nbytes_t'(chunk.nbytes);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (emit) begin
      w_data_o <= flush_q ? acc_data_q : wide_data[63:0];
      w_strb_o <= flush_q ? acc_strb_q : wide_strb[7:0];
      w_last_o <= beat_cnt_q == beats - 1'b1;
    end
    if (load) begin
      acc_data_q <= '0;
      acc_strb_q <= '0;
    end else if (take) begin
      // Overflow past byte 7 opens the next beat
      acc_data_q <= new_fill[3] ? wide_data[127:64] : wide_data[63:0];
      acc_strb_q <= new_fill[3] ? wide_strb[15:8] : wide_strb[7:0];
    end
  end

endmodule

`default_nettype wire

// File: design/vstu_top.sv
//////////////////////////////////////////////////////////////////////
// Vector store unit top level
// Instruction queue, AW generator, lane collector and W packer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "vstu_defines.svh"

module vstu_top import vstu_pkg::*; (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Store requests from the sequencer
  input  logic                                         req_valid_i,
  output logic                                         req_ready_o,
  input  logic [`VSTU_ID_W-1:0]                         req_id_i,
  input  logic [31:0]                                  req_addr_i,
  input  logic [7:0]                                   req_vl_i,
  input  eew_e                                         req_eew_i,
  input  logic                                         req_vm_i,
  // Lane operands
  input  logic [`VSTU_NR_LANES-1:0][`VSTU_LANE_W-1:0]   lane_data_i,
  input  logic [`VSTU_NR_LANES-1:0][`VSTU_LANE_W/8-1:0] lane_mask_i,
  input  logic                                         lane_valid_i,
  output logic                                         lane_ready_o,
  // AXI write channels
  output logic [31:0]                                  aw_addr_o,
  output logic [`VSTU_LEN_W-1:0]                        aw_len_o,
  output logic                                         aw_valid_o,
  input  logic                                         aw_ready_i,
  output logic [`VSTU_AXI_DATA_W-1:0]                   w_data_o,
  output logic [`VSTU_AXI_DATA_W/8-1:0]                 w_strb_o,
  output logic                                         w_last_o,
  output logic                                         w_valid_o,
  input  logic                                         w_ready_i,
  input  logic                                         b_valid_i,
  output logic                                         b_ready_o,
  // Completion
  output logic                                         done_valid_o,
  output logic [`VSTU_ID_W-1:0]                         done_id_o,
  output logic                                         store_pending_o
);

  store_req_t req;

  issue_if issue ();
  chunk_if chunk ();

  assign req = '{id: req_id_i, addr: req_addr_i, vl: req_vl_i, eew: req_eew_i, vm: req_vm_i};

  vstu_insn_queue u_queue (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_i (req),
    .b_valid_i, .b_ready_o,
    .done_valid_o, .done_id_o, .store_pending_o,
    .issue (issue.queue)
  );

  vstu_addrgen u_addrgen (
    .clk_i, .rst_ni,
    .issue (issue.gen),
    .aw_addr_o, .aw_len_o, .aw_valid_o, .aw_ready_i
  );

  vstu_operand_collector u_collector (
    .clk_i, .rst_ni,
    .issue (issue.gen),
    .lane_data_i, .lane_mask_i, .lane_valid_i, .lane_ready_o,
    .chunk (chunk.src)
  );

  vstu_beat_packer u_packer (
    .clk_i, .rst_ni,
    .issue (issue.pack),
    .chunk (chunk.snk),
    .w_data_o, .w_strb_o, .w_last_o, .w_valid_o, .w_ready_i
  );

endmodule

`default_nettype wire

// File: verif/tb_vstu.sv
//////////////////////////////////////////////////////////////////////
// Vector store unit testbench
// Lane model, AXI write slave and directed store checks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "vstu_defines.svh"

module tb_vstu import vstu_pkg::*; ;

  // Roughly 380 beats at half rate under stalls plus per-store overhead
  localparam int unsigned WATCHDOG_NS = 20000;

  logic                                         clk_i, rst_ni;
  logic                                         req_valid_i, req_ready_o;
  logic [`VSTU_ID_W-1:0]                         req_id_i;
  logic [31:0]                                  req_addr_i;
  logic [7:0]                                   req_vl_i;
  eew_e                                         req_eew_i;
  logic                                         req_vm_i;
  logic [`VSTU_NR_LANES-1:0][`VSTU_LANE_W-1:0]   lane_data_i;
  logic [`VSTU_NR_LANES-1:0][`VSTU_LANE_W/8-1:0] lane_mask_i;
  logic                                         lane_valid_i, lane_ready_o;
  logic [31:0]                                  aw_addr_o;
  logic [`VSTU_LEN_W-1:0]                        aw_len_o;
  logic                                         aw_valid_o, aw_ready_i;
  logic [`VSTU_AXI_DATA_W-1:0]                   w_data_o;
  logic [`VSTU_AXI_DATA_W/8-1:0]                 w_strb_o;
  logic                                         w_last_o, w_valid_o, w_ready_i;
  logic                                         b_valid_i, b_ready_o;
  logic                                         done_valid_o, store_pending_o;
  logic [`VSTU_ID_W-1:0]                         done_id_o;

  // Slave side logs filled at the falling edge
  logic [31:0]            aw_addr_log[$];
  logic [`VSTU_LEN_W-1:0] aw_len_log[$];
  logic [63:0]            w_data_log[$];
  logic [7:0]             w_strb_log[$];
  logic                   w_last_log[$];
  logic [`VSTU_ID_W-1:0]  done_log[$];
  store_req_t             lane_work[$];
  int unsigned            aw_cnt, wlast_cnt, b_cnt;
  logic                   stall_en, hold_b;
  logic [31:0]            lfsr_q;

  vstu_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Stream byte k of a store depends on the whole byte index
  function automatic logic [7:0] stream_byte(input store_req_t r, input int unsigned k);
    int unsigned v;
    v = k ^ (k >> 8) ^ (r.id * 37);
    return v[7:0];
  endfunction

  // Lane mask bit of element e
  function automatic logic mask_bit(input store_req_t r, input int unsigned e);
    return ((e + r.id) % 3) != 0;
  endfunction

  task automatic stop_failed();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_failure(input string msg);
    $display("At %0t ns the run failed: %s", $time, msg);
    stop_failed();
  endtask

  task automatic expect_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      stop_failed();
    end
  endtask

  // Lane word t of a store with element e in lane e % 4
  task automatic drive_lane_word(input store_req_t r, input int unsigned t);
    int unsigned sz, nb, k, e, pos;
    lane_data_i = '0;
    lane_mask_i = '0;
    sz = 1 << r.eew;
    nb = r.vl * sz;
    for (k = 32 * t; k < 32 * t + 32 && k < nb; k++) begin
      e   = k / sz;
      pos = ((e / `VSTU_NR_LANES) % (8 / sz)) * sz + k % sz;
      lane_data_i[e % `VSTU_NR_LANES][pos*8 +: 8] = stream_byte(r, k);
      lane_mask_i[e % `VSTU_NR_LANES][pos]        = mask_bit(r, e);
    end
  endtask

  // Lane model feeds accepted stores in order
  initial begin : lane_model
    store_req_t  r;
    int unsigned t, ntr;
    logic        fired;
    forever begin
      @(posedge clk_i);
      #1;
      if (lane_work.size() != 0) begin
        r   = lane_work.pop_front();
        ntr = (r.vl * (1 << r.eew) + 31) / 32;
        for (t = 0; t < ntr; t++) begin
          drive_lane_word(r, t);
          lane_valid_i = 1'b1;
          do begin
            @(negedge clk_i);
            fired = lane_ready_o;
            @(posedge clk_i);
            #1;
          end while (!fired);
          lane_valid_i = 1'b0;
        end
      end
    end
  end

  // AW, W and B slave
  initial begin : axi_slave
    forever begin
      @(negedge clk_i);
      if (aw_valid_o && aw_ready_i) begin
        aw_addr_log.push_back(aw_addr_o);
        aw_len_log.push_back(aw_len_o);
        aw_cnt++;
      end
      if (w_valid_o && w_ready_i) begin
        w_data_log.push_back(w_data_o);
        w_strb_log.push_back(w_strb_o);
        w_last_log.push_back(w_last_o);
        if (w_last_o) wlast_cnt++;
      end
      if (b_valid_i && b_ready_o) b_cnt++;
      if (done_valid_o) done_log.push_back(done_id_o);
      @(posedge clk_i);
      #1;
      aw_ready_i = 1'b1;
      w_ready_i  = 1'b1;
      if (stall_en) begin
        aw_ready_i = lfsr_q[0];
        lfsr_q     = lfsr_next(lfsr_q);
        w_ready_i  = lfsr_q[0];
        lfsr_q     = lfsr_next(lfsr_q);
      end
      // A response only once both AW and the last W beat are in
      b_valid_i = !hold_b && (b_cnt < aw_cnt) && (b_cnt < wlast_cnt);
    end
  end

  task automatic send_req(input store_req_t r);
    logic fired;
    req_id_i    = r.id;
    req_addr_i  = r.addr;
    req_vl_i    = r.vl;
    req_eew_i   = r.eew;
    req_vm_i    = r.vm;
    req_valid_i = 1'b1;
    do begin
      @(negedge clk_i);
      fired = req_ready_o;
      @(posedge clk_i);
      #1;
    end while (!fired);
    req_valid_i = 1'b0;
    lane_work.push_back(r);
  endtask

  task automatic wait_for_done(input int unsigned n);
    while (done_log.size() < n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Burst of one store against the beat rule
  task automatic check_store(input store_req_t r);
    int unsigned sz, nb, off, beats, i, b, p, k;
    logic [63:0] exp_data, care;
    logic [7:0]  exp_strb;
    sz    = 1 << r.eew;
    nb    = r.vl * sz;
    off   = r.addr % 8;
    beats = (off + nb + 7) / 8;
    assert (aw_addr_log.size() != 0) else report_failure("no AW burst was seen");
    expect_eq(aw_addr_log.pop_front(), {r.addr[31:3], 3'b000}, "AW address");
    expect_eq(aw_len_log.pop_front(), beats - 1, "AW length");
    for (i = 0; i < beats; i++) begin
      assert (w_data_log.size() != 0) else report_failure("W burst ended too early");
      exp_data = '0;
      care     = '0;
      exp_strb = '0;
      for (b = 0; b < 8; b++) begin
        p = i * 8 + b;
        if (p >= off && p - off < nb) begin
          k                   = p - off;
          exp_data[b*8 +: 8]  = stream_byte(r, k);
          care[b*8 +: 8]      = 8'hff;
          exp_strb[b]         = r.vm || mask_bit(r, k / sz);
        end
      end
      expect_eq(w_data_log.pop_front() & care, exp_data,
                $sformatf("id %0d beat %0d W data", r.id, i));
      expect_eq(w_strb_log.pop_front(), exp_strb,
                $sformatf("id %0d beat %0d W strobe", r.id, i));
      expect_eq(w_last_log.pop_front(), i == beats - 1,
                $sformatf("id %0d beat %0d W last", r.id, i));
    end
  endtask

  task automatic run_single(input store_req_t r);
    send_req(r);
    wait_for_done(1);
    expect_eq(done_log.pop_front(), r.id, "done id");
    check_store(r);
    expect_eq(w_data_log.size(), 0, "W beats left over");
  endtask

  task automatic aligned_stores();
    run_single('{id: 3'd0, addr: 32'h1000, vl: 8'd40, eew: EW8,  vm: 1'b1});
    run_single('{id: 3'd1, addr: 32'h1040, vl: 8'd20, eew: EW16, vm: 1'b1});
    run_single('{id: 3'd2, addr: 32'h2000, vl: 8'd12, eew: EW32, vm: 1'b1});
    run_single('{id: 3'd3, addr: 32'h3000, vl: 8'd9,  eew: EW64, vm: 1'b1});
  endtask

  task automatic unaligned_stores();
    run_single('{id: 3'd4, addr: 32'h1003, vl: 8'd13,  eew: EW16, vm: 1'b1});
    // Longest burst of 129 beats
    run_single('{id: 3'd5, addr: 32'h2005, vl: 8'd128, eew: EW64, vm: 1'b1});
    run_single('{id: 3'd6, addr: 32'h3007, vl: 8'd1,   eew: EW8,  vm: 1'b1});
  endtask

  task automatic masked_stores();
    run_single('{id: 3'd1, addr: 32'h4000, vl: 8'd37, eew: EW8,  vm: 1'b0});
    run_single('{id: 3'd2, addr: 32'h4102, vl: 8'd11, eew: EW32, vm: 1'b0});
    run_single('{id: 3'd3, addr: 32'h4200, vl: 8'd10, eew: EW64, vm: 1'b0});
  endtask

  // Same stores under random AW and W back-pressure
  task automatic stalled_stores();
    stall_en = 1'b1;
    aligned_stores();
    unaligned_stores();
    masked_stores();
    stall_en = 1'b0;
  endtask

  task automatic queue_full_stores();
    store_req_t  r[4];
    int unsigned n, base;
    for (n = 0; n < 4; n++) begin
      r[n] = '{id: 3'(n + 4), addr: 32'h5000 + n * 32'h101, vl: 8'd8, eew: EW32, vm: n[0]};
    end
    hold_b = 1'b1;
    base   = wlast_cnt;
    for (n = 0; n < 4; n++) send_req(r[n]);
    @(negedge clk_i);
    expect_eq(req_ready_o, 1'b0, "request ready with four held");
    // Bursts drain while commit waits on B
    while (wlast_cnt < base + 4) begin
      @(posedge clk_i);
      #1;
    end
    @(negedge clk_i);
    expect_eq(req_ready_o, 1'b0, "request ready before B");
    expect_eq(store_pending_o, 1'b1, "pending before B");
    expect_eq(b_ready_o, 1'b1, "B ready with issued stores waiting");
    expect_eq(done_log.size(), 0, "done count before B");
    @(posedge clk_i);
    #1;
    hold_b = 1'b0;
    wait_for_done(4);
    @(negedge clk_i);
    expect_eq(store_pending_o, 1'b0, "pending after the last done");
    expect_eq(b_ready_o, 1'b0, "B ready with nothing to commit");
    for (n = 0; n < 4; n++) begin
      expect_eq(done_log.pop_front(), r[n].id, "done id order");
      check_store(r[n]);
    end
    @(posedge clk_i);
    #1;
    expect_eq(req_ready_o, 1'b1, "request ready after commit");
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the stores did not complete within %0d ns", WATCHDOG_NS);
    stop_failed();
  end

  initial begin : main
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_id_i     = '0;
    req_addr_i   = '0;
    req_vl_i     = '0;
    req_eew_i    = EW8;
    req_vm_i     = 1'b1;
    lane_data_i  = '0;
    lane_mask_i  = '0;
    lane_valid_i = 1'b0;
    aw_ready_i   = 1'b1;
    w_ready_i    = 1'b1;
    b_valid_i    = 1'b0;
    stall_en     = 1'b0;
    hold_b       = 1'b0;
    lfsr_q       = 32'hb9b5217d;
    aw_cnt       = 0;
    wlast_cnt    = 0;
    b_cnt        = 0;
    @(negedge clk_i);
    expect_eq({req_ready_o, lane_ready_o, aw_valid_o, w_valid_o, b_ready_o,
               done_valid_o, store_pending_o}, '0, "outputs in reset");
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    aligned_stores();
    unaligned_stores();
    masked_stores();
    stalled_stores();
    queue_full_stores();
    expect_eq(aw_addr_log.size() + w_data_log.size(), 0, "bursts left over at the end");
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/vstu_pkg.sv
design/vstu_if.sv
design/vstu_insn_queue.sv
design/vstu_addrgen.sv
design/vstu_operand_collector.sv
design/vstu_beat_packer.sv
design/vstu_top.sv
verif/tb_vstu.sv
